// File: vlog.f
+incdir+include
hw/flash_ctrl_pkg.sv
hw/spi_cmd_if.sv
hw/spi_flash_engine.sv
hw/region_cfg.sv
hw/flash_sequencer.sv
hw/flash_ctrl_top.sv
dv/spi_flash_model.sv
dv/flash_ctrl_assert.sv
dv/flash_ctrl_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= flash_ctrl_tb
FLIST     ?= vlog.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Testbench passed

SRCS := $(shell grep -v '^+' $(FLIST))
HDRS := $(wildcard include/*.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(HDRS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

run: $(BIN)
	@out="$$(./$(BIN))"; status=$$?; echo "$$out"; \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: dv/flash_ctrl_tb.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module flash_ctrl_tb;
	import flash_ctrl_pkg::*;

	// boot 3, param save 3+3, coe save 4+4, code 2, load 3
	localparam int TOTAL_PAGES = 22;
	localparam int WATCHDOG_CYCLES =
		TOTAL_PAGES * `FLASH_PAGE_BYTES * (16 * `SCK_HALF_DIV) * 4;
	localparam int CODE_BASE = 5 * `CODE_PACKET_SPAN;

	logic                   clk, rst_n;
	logic                   cs_n, sck, mosi, miso;
	logic                   req_valid, req_ready;
	req_kind_e              req_kind;
	logic [2:0]             code_packet;
	logic                   fifo_valid, fifo_ready;
	logic [15:0]            fifo_data;
	logic                   ddr_valid, ddr_ready;
	logic [`DDR_ADDR_W-1:0] ddr_addr;
	logic [`DDR_DATA_W-1:0] ddr_data;
	logic                   load_done;

	logic [7:0]  ref_mem [int];
	logic [31:0] rng_fifo, rng_ddr;
	logic [63:0] exp_data;
	string       test_name;
	int          errors, checks;
	int          exp_base, exp_words, word_idx, prog_addr;
	int          load_done_cnt, ddr_total, done_before, total_before;
	bit          gaps_on;
	bit          fifo_taken;

	flash_ctrl_top flash_ctrl_top_inst (
		.i_clk (clk), .i_rst_n (rst_n),
		.o_flash_cs_n (cs_n), .o_flash_sck (sck), .o_flash_mosi (mosi),
		.i_flash_miso (miso),
		.i_req_valid (req_valid), .o_req_ready (req_ready),
		.i_req_kind (req_kind), .i_code_packet (code_packet),
		.i_fifo_valid (fifo_valid), .o_fifo_ready (fifo_ready), .i_fifo_data (fifo_data),
		.o_ddr_wr_valid (ddr_valid), .i_ddr_wr_ready (ddr_ready),
		.o_ddr_wr_addr (ddr_addr), .o_ddr_wr_data (ddr_data),
		.o_load_done (load_done)
	);

	spi_flash_model flash_model_inst (
		.i_cs_n (cs_n), .i_sck (sck), .i_mosi (mosi), .o_miso (miso)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic logic [7:0] ref_byte(input int a);
		return ref_mem.exists(a) ? ref_mem[a] : 8'hFF;
	endfunction

	// first byte lands in the top bits
	function automatic logic [63:0] packed_word(input int a);
		logic [63:0] w;
		w = 64'd0;
		for (int i = 0; i < 8; i++)
			w = {w[55:0], ref_byte(a + i)};
		return w;
	endfunction

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	//--------------------------------------------------
	// ddr sink, checks the word about to transfer
	//--------------------------------------------------
	always @(negedge clk) begin
		if (gaps_on) begin
			rng_ddr   = xorshift(rng_ddr);
			ddr_ready = (rng_ddr[1:0] != 2'd0);
		end else begin
			ddr_ready = 1'b1;
		end
		if (rst_n && ddr_valid && ddr_ready) begin
			exp_data = packed_word(exp_base + 8 * word_idx);
			checks++;
			assert (word_idx < exp_words) else begin
				$display("%s: DDR write beyond the expected word count", test_name);
				errors++;
			end
			assert (ddr_data == exp_data) else begin
				$display("[ERROR] %s data: expected %h actual %h", test_name, exp_data, ddr_data);
				errors++;
			end
			assert (ddr_addr == `DDR_ADDR_W'(word_idx * `DDR_ADDR_STEP)) else begin
				$display("[ERROR] %s addr: expected %h actual %h", test_name,
					word_idx * `DDR_ADDR_STEP, ddr_addr);
				errors++;
			end
			word_idx++;
			ddr_total++;
		end
		if (rst_n && load_done)
			load_done_cnt++;
	end

	// fifo source, the reference follows each consumed word
	always @(negedge clk) begin
		if (fifo_taken) begin
			fifo_valid = 1'b0;
			fifo_taken = 1'b0;
		end
		if (rst_n && !fifo_valid) begin
			rng_fifo = xorshift(rng_fifo);
			if (!gaps_on || rng_fifo[1:0] != 2'd0) begin
				fifo_valid = 1'b1;
				fifo_data  = rng_fifo[31:16];
			end
		end
		// word moves on the coming rising edge
		if (rst_n && fifo_valid && fifo_ready) begin
			ref_mem[prog_addr]     = fifo_data[15:8];
			ref_mem[prog_addr + 1] = fifo_data[7:0];
			prog_addr  = prog_addr + 2;
			fifo_taken = 1'b1;
		end
	end

	task automatic expect_load(input string name, input int base, input int pages);
		test_name = name;
		exp_base  = base;
		exp_words = pages * `FLASH_PAGE_BYTES / 8;
		word_idx  = 0;
	endtask

	task automatic send_request(input req_kind_e kind, input logic [2:0] packet);
		@(negedge clk);
		while (!req_ready)
			@(negedge clk);
		req_valid   = 1'b1;
		req_kind    = kind;
		code_packet = packet;
		@(negedge clk);
		req_valid = 1'b0;
	endtask

	task automatic finish_load(input int n);
		wait (load_done_cnt == n);
		checks++;
		assert (word_idx == exp_words) else begin
			$display("[ERROR] %s words: expected %0d actual %0d", test_name, exp_words, word_idx);
			errors++;
		end
	endtask

	task automatic compare_flash(input int base, input int bytes);
		for (int a = base; a < base + bytes; a++) begin
			checks++;
			assert (flash_model_inst.peek_byte(a) == ref_byte(a)) else begin
				$display("[ERROR] %s flash %h: expected %h actual %h", test_name, a,
					ref_byte(a), flash_model_inst.peek_byte(a));
				errors++;
			end
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: the controller did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		req_valid = 1'b0;
		req_kind = REQ_LOAD_PARAM;
		code_packet = 3'd0;
		fifo_valid = 1'b0;
		fifo_data = 16'h0000;
		fifo_taken = 1'b0;
		ddr_ready = 1'b1;
		errors = 0;
		checks = 0;
		load_done_cnt = 0;
		ddr_total = 0;
		gaps_on = 1'b0;
		rng_fifo = 32'd5417;
		rng_ddr = xorshift(32'd5417);
		// parameter and coefficient content before boot
		for (int a = 0; a < `COE_PAGES * `FLASH_PAGE_BYTES; a++) begin
			rng_fifo = xorshift(rng_fifo);
			ref_mem[`PARAM_BASE + a] = rng_fifo[7:0];
			ref_mem[`COE_BASE + a]   = rng_fifo[15:8];
			flash_model_inst.preload_byte(`PARAM_BASE + a, rng_fifo[7:0]);
			flash_model_inst.preload_byte(`COE_BASE + a, rng_fifo[15:8]);
		end
		expect_load("boot_load", `PARAM_BASE, `PARAM_PAGES);
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		finish_load(1);

		prog_addr = `PARAM_BASE;
		expect_load("param_save", `PARAM_BASE, `PARAM_PAGES);
		send_request(REQ_SAVE_PARAM, 3'd0);
		finish_load(2);
		compare_flash(`PARAM_BASE, `PARAM_PAGES * `FLASH_PAGE_BYTES);

		gaps_on   = 1'b1;
		prog_addr = `COE_BASE;
		expect_load("coe_backpressure", `COE_BASE, `COE_PAGES);
		send_request(REQ_SAVE_COE, 3'd0);
		finish_load(3);
		compare_flash(`COE_BASE, `COE_PAGES * `FLASH_PAGE_BYTES);
		gaps_on = 1'b0;

		prog_addr    = CODE_BASE;
		done_before  = load_done_cnt;
		total_before = ddr_total;
		expect_load("code_save", CODE_BASE, 0);
		send_request(REQ_SAVE_CODE, 3'd5);
		while (!req_ready)
			@(negedge clk);
		compare_flash(CODE_BASE, `CODE_PAGES * `FLASH_PAGE_BYTES);
		checks++;
		assert (flash_model_inst.erased_blocks(CODE_BASE) == 1) else begin
			$display("[ERROR] code_save erases: expected 1 actual %0d",
				flash_model_inst.erased_blocks(CODE_BASE));
			errors++;
		end
		checks++;
		assert (ddr_total == total_before && load_done_cnt == done_before) else begin
			$display("code_save: a DDR write or load done appeared after a code save");
			errors++;
		end

		expect_load("param_reload", `PARAM_BASE, `PARAM_PAGES);
		send_request(REQ_LOAD_PARAM, 3'd0);
		finish_load(done_before + 1);
		repeat (4) @(negedge clk);

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: dv/flash_ctrl_assert.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module flash_ctrl_assert (
	input logic                   i_clk,
	input logic                   i_rst_n,
	input logic                   i_cs_n,
	input logic                   i_sck,
	input logic                   i_ddr_valid,
	input logic                   i_ddr_ready,
	input logic [`DDR_ADDR_W-1:0] i_ddr_addr,
	input logic [`DDR_DATA_W-1:0] i_ddr_data,
	input logic                   i_req_ready,
	input logic                   i_load_done
);

	// ddr word held until accepted
	ddr_hold: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_ddr_valid && !i_ddr_ready) |=>
		(i_ddr_valid && $stable(i_ddr_addr) && $stable(i_ddr_data)))
		else $error("ddr write changed before it was accepted");

	sck_idle: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_cs_n |-> !i_sck)
		else $error("sck toggled with chip select high");

	// flash traffic or a pending ddr word means an operation is running
	busy_req: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(!i_cs_n || i_ddr_valid) |-> !i_req_ready)
		else $error("request port ready during an operation");

	done_pulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_load_done |=> !i_load_done)
		else $error("load done held longer than one cycle");

endmodule

bind flash_ctrl_top flash_ctrl_assert flash_ctrl_assert_inst (
	.i_clk       (i_clk),
	.i_rst_n     (i_rst_n),
	.i_cs_n      (o_flash_cs_n),
	.i_sck       (o_flash_sck),
	.i_ddr_valid (o_ddr_wr_valid),
	.i_ddr_ready (i_ddr_wr_ready),
	.i_ddr_addr  (o_ddr_wr_addr),
	.i_ddr_data  (o_ddr_wr_data),
	.i_req_ready (o_req_ready),
	.i_load_done (o_load_done)
);

// File: dv/spi_flash_model.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module spi_flash_model (
	input  logic i_cs_n,
	input  logic i_sck,
	input  logic i_mosi,
	output logic o_miso
);
	import flash_ctrl_pkg::*;

	// sparse array, absent bytes read as erased
	logic [7:0] mem [int];
	int         erase_cnt [int];

	logic [7:0]  r_in_sr;
	logic [7:0]  r_out_sr;
	logic [7:0]  r_op;
	logic [23:0] r_addr;
	logic [23:0] r_rd_addr;
	logic        r_wel;
	int          r_bits;
	int          k;

	task automatic preload_byte(input int addr, input logic [7:0] data);
		mem[addr] = data;
	endtask

	function automatic logic [7:0] peek_byte(input int addr);
		return mem.exists(addr) ? mem[addr] : 8'hFF;
	endfunction

	function automatic int erased_blocks(input int addr);
		return erase_cnt.exists(addr) ? erase_cnt[addr] : 0;
	endfunction

	initial begin
		o_miso = 1'b0;
		r_wel  = 1'b0;
		r_bits = 0;
		r_op   = 8'h00;
	end

	always @(negedge i_cs_n) begin
		r_bits = 0;
	end

	//--------------------------------------------------
	// command decode on rising sck
	//--------------------------------------------------
	always @(posedge i_sck) begin
		if (!i_cs_n) begin
			r_in_sr = {r_in_sr[6:0], i_mosi};
			r_bits  = r_bits + 1;
			if (r_bits % 8 == 0) begin
				k = r_bits / 8 - 1;
				if (k == 0) begin
					r_op = r_in_sr;
					if (r_in_sr == OP_WREN)
						r_wel = 1'b1;
				end else if (k <= 3) begin
					r_addr = {r_addr[15:0], r_in_sr};
					if (k == 3 && r_op == OP_READ) begin
						r_out_sr  = peek_byte(int'(r_addr));
						r_rd_addr = r_addr + 24'd1;
					end
				end else if (r_op == OP_READ) begin
					r_out_sr  = peek_byte(int'(r_rd_addr));
					r_rd_addr = r_rd_addr + 24'd1;
				end else if (r_op == OP_PROGRAM && r_wel) begin
					// programming only clears bits
					mem[int'(r_addr) + k - 4] = peek_byte(int'(r_addr) + k - 4) & r_in_sr;
				end
			end
		end
	end

	// read data shifts out on falling sck
	always @(negedge i_sck) begin
		if (!i_cs_n && r_op == OP_READ && r_bits >= 32) begin
			o_miso   = r_out_sr[7];
			r_out_sr = {r_out_sr[6:0], 1'b0};
		end
	end

	always @(posedge i_cs_n) begin
		if (r_op == OP_ERASE && r_wel && r_bits == 32) begin
			for (int a = 0; a < `FLASH_BLOCK_BYTES; a++) begin
				if (mem.exists(int'({r_addr[23:16], 16'h0000}) + a))
					mem.delete(int'({r_addr[23:16], 16'h0000}) + a);
			end
			erase_cnt[int'({r_addr[23:16], 16'h0000})] =
				erased_blocks(int'({r_addr[23:16], 16'h0000})) + 1;
		end
		if (r_op == OP_ERASE || r_op == OP_PROGRAM)
			r_wel = 1'b0;
	end

endmodule

// File: hw/flash_ctrl_top.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module flash_ctrl_top (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	output logic                      o_flash_cs_n,
	output logic                      o_flash_sck,
	output logic                      o_flash_mosi,
	input  logic                      i_flash_miso,
	input  logic                      i_req_valid,
	output logic                      o_req_ready,
	input  flash_ctrl_pkg::req_kind_e i_req_kind,
	input  logic [2:0]                i_code_packet,
	input  logic                      i_fifo_valid,
	output logic                      o_fifo_ready,
	input  logic [`FIFO_DATA_W-1:0]   i_fifo_data,
	output logic                      o_ddr_wr_valid,
	input  logic                      i_ddr_wr_ready,
	output logic [`DDR_ADDR_W-1:0]    o_ddr_wr_addr,
	output logic [`DDR_DATA_W-1:0]    o_ddr_wr_data,
	output logic                      o_load_done
);

	logic                     op_pending;
	logic                     op_save;
	logic                     op_reload;
	logic [`FLASH_ADDR_W-1:0] op_base;
	logic [15:0]              op_pages;
	logic                     op_start;
	logic                     op_done;

	spi_cmd_if spi_cmd ();

	region_cfg region_cfg_inst (
		.i_clk         (i_clk),
		.i_rst_n       (i_rst_n),
		.i_req_valid   (i_req_valid),
		.i_req_kind    (i_req_kind),
		.i_code_packet (i_code_packet),
		.o_req_ready   (o_req_ready),
		.i_op_start    (op_start),
		.i_op_done     (op_done),
		.o_op_pending  (op_pending),
		.o_op_save     (op_save),
		.o_op_reload   (op_reload),
		.o_op_base     (op_base),
		.o_op_pages    (op_pages)
	);

	flash_sequencer flash_sequencer_inst (
		.i_clk          (i_clk),
		.i_rst_n        (i_rst_n),
		.i_op_pending   (op_pending),
		.i_op_save      (op_save),
		.i_op_reload    (op_reload),
		.i_op_base      (op_base),
		.i_op_pages     (op_pages),
		.o_op_start     (op_start),
		.o_op_done      (op_done),
		.spi            (spi_cmd.master),
		.i_fifo_valid   (i_fifo_valid),
		.o_fifo_ready   (o_fifo_ready),
		.i_fifo_data    (i_fifo_data),
		.o_ddr_wr_valid (o_ddr_wr_valid),
		.i_ddr_wr_ready (i_ddr_wr_ready),
		.o_ddr_wr_addr  (o_ddr_wr_addr),
		.o_ddr_wr_data  (o_ddr_wr_data),
		.o_load_done    (o_load_done)
	);

	spi_flash_engine spi_flash_engine_inst (
		.i_clk   (i_clk),
		.i_rst_n (i_rst_n),
		.spi     (spi_cmd.slave),
		.o_cs_n  (o_flash_cs_n),
		.o_sck   (o_flash_sck),
		.o_mosi  (o_flash_mosi),
		.i_miso  (i_flash_miso)
	);

endmodule

// File: hw/flash_sequencer.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module flash_sequencer (
	input  logic                     i_clk,
	input  logic                     i_rst_n,
	input  logic                     i_op_pending,
	input  logic                     i_op_save,
	input  logic                     i_op_reload,
	input  logic [`FLASH_ADDR_W-1:0] i_op_base,
	input  logic [15:0]              i_op_pages,
	output logic                     o_op_start,
	output logic                     o_op_done,
	spi_cmd_if.master                spi,
	input  logic                     i_fifo_valid,
	output logic                     o_fifo_ready,
	input  logic [`FIFO_DATA_W-1:0]  i_fifo_data,
	output logic                     o_ddr_wr_valid,
	input  logic                     i_ddr_wr_ready,
	output logic [`DDR_ADDR_W-1:0]   o_ddr_wr_addr,
	output logic [`DDR_DATA_W-1:0]   o_ddr_wr_data,
	output logic                     o_load_done
);
	import flash_ctrl_pkg::*;

	localparam logic [`FLASH_ADDR_W-1:0] BLOCK_MASK = `FLASH_ADDR_W'(`FLASH_BLOCK_BYTES - 1);
	localparam logic [7:0] PAGE_WORDS = 8'(`FLASH_PAGE_BYTES / 2);

	seq_state_e               r_state;
	logic                     r_issued;
	logic [`FLASH_ADDR_W-1:0] r_base;
	logic [`FLASH_ADDR_W-1:0] r_flash_addr;
	logic [15:0]              r_pages;
	logic                     r_reload;
	logic [15:0]              r_page_cnt;
	logic [15:0]              r_wait_cnt;
	// read side packing
	logic [`DDR_DATA_W-1:0]   r_pack;
	logic [2:0]               r_pack_cnt;
	logic                     r_ddr_valid;
	logic [`DDR_ADDR_W-1:0]   r_ddr_addr;
	logic [`DDR_DATA_W-1:0]   r_ddr_data;
	logic [15:0]              r_word_cnt;
	logic                     r_load_done;
	// program side unpacking
	logic [`FIFO_DATA_W-1:0]  r_fifo_word;
	logic                     r_word_full;
	logic                     r_half;
	logic [7:0]               r_fifo_cnt;

	logic [`FLASH_ADDR_W-1:0] w_next_addr;
	logic [15:0]              w_wait_limit;
	logic                     w_wait_done;
	logic                     w_last_page;
	logic                     w_load_start;
	logic                     w_rd_fire;
	logic                     w_ddr_fire;
	logic                     w_fifo_fire;

	assign w_next_addr  = r_flash_addr + `FLASH_ADDR_W'(`FLASH_PAGE_BYTES);
	assign w_wait_limit = (r_state == SEQ_ERASE_WAIT) ? 16'(`ERASE_WAIT_CYCLES) :
		16'(`PROGRAM_WAIT_CYCLES);
	assign w_wait_done  = (r_wait_cnt == w_wait_limit - 16'd1);
	assign w_last_page  = (r_page_cnt == r_pages - 16'd1);
	// boot or explicit load, or reload after the last program page
	assign w_load_start = (r_state == SEQ_IDLE && i_op_pending && !i_op_save) ||
		(r_state == SEQ_PROG_WAIT && w_wait_done && w_last_page && r_reload);
	assign w_rd_fire    = spi.rd_valid && spi.rd_ready;
	assign w_ddr_fire   = r_ddr_valid && i_ddr_wr_ready;
	assign w_fifo_fire  = i_fifo_valid && o_fifo_ready;

	//--------------------------------------------------
	// operation fsm
	//--------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state      <= SEQ_IDLE;
			r_issued     <= 1'b0;
			r_flash_addr <= '0;
			r_page_cnt   <= 16'd0;
			r_wait_cnt   <= 16'd0;
		end else begin
			if (spi.cmd_done) begin
				r_issued <= 1'b0;
			end else if (spi.cmd_valid && spi.cmd_ready) begin
				r_issued <= 1'b1;
			end
			case (r_state)
				SEQ_IDLE: begin
					if (i_op_pending) begin
						r_flash_addr <= i_op_base;
						r_page_cnt   <= 16'd0;
						r_state      <= i_op_save ? SEQ_ERASE_WREN : SEQ_READ;
					end
				end
				SEQ_ERASE_WREN: if (spi.cmd_done) r_state <= SEQ_ERASE;
				SEQ_ERASE:      if (spi.cmd_done) r_state <= SEQ_ERASE_WAIT;
				SEQ_PROG_WREN:  if (spi.cmd_done) r_state <= SEQ_PROGRAM;
				SEQ_PROGRAM:    if (spi.cmd_done) r_state <= SEQ_PROG_WAIT;
				SEQ_ERASE_WAIT: begin
					r_wait_cnt <= r_wait_cnt + 16'd1;
					if (w_wait_done) begin
						r_wait_cnt <= 16'd0;
						r_state    <= SEQ_PROG_WREN;
					end
				end
				SEQ_PROG_WAIT: begin
					r_wait_cnt <= r_wait_cnt + 16'd1;
					if (w_wait_done) begin
						r_wait_cnt <= 16'd0;
						if (w_last_page) begin
							r_page_cnt   <= 16'd0;
							r_flash_addr <= r_base;
							r_state      <= r_reload ? SEQ_READ : SEQ_DONE;
						end else begin
							r_page_cnt   <= r_page_cnt + 16'd1;
							r_flash_addr <= w_next_addr;
							// new erase block starts here
							if ((w_next_addr & BLOCK_MASK) == '0) begin
								r_state <= SEQ_ERASE_WREN;
							end else begin
								r_state <= SEQ_PROG_WREN;
							end
						end
					end
				end
				SEQ_READ: begin
					if (spi.cmd_done) begin
						if (w_last_page) begin
							r_state <= SEQ_LOAD_WAIT;
						end else begin
							r_page_cnt   <= r_page_cnt + 16'd1;
							r_flash_addr <= w_next_addr;
						end
					end
				end
				SEQ_LOAD_WAIT: if (!r_ddr_valid) r_state <= SEQ_DONE;
				default:       r_state <= SEQ_IDLE;
			endcase
		end
	end

	always_ff @(posedge i_clk) begin
		if (r_state == SEQ_IDLE && i_op_pending) begin
			r_base   <= i_op_base;
			r_pages  <= i_op_pages;
			r_reload <= i_op_reload;
		end
	end

	assign o_op_start = (r_state == SEQ_IDLE) && i_op_pending;
	assign o_op_done  = (r_state == SEQ_DONE);

	// command channel
	always_comb begin
		spi.cmd_valid = 1'b0;
		spi.cmd_op    = OP_READ;
		spi.cmd_len   = 16'd0;
		case (r_state)
			SEQ_ERASE_WREN, SEQ_PROG_WREN: begin
				spi.cmd_valid = !r_issued;
				spi.cmd_op    = OP_WREN;
			end
			SEQ_ERASE: begin
				spi.cmd_valid = !r_issued;
				spi.cmd_op    = OP_ERASE;
			end
			SEQ_PROGRAM: begin
				spi.cmd_valid = !r_issued;
				spi.cmd_op    = OP_PROGRAM;
				spi.cmd_len   = 16'(`FLASH_PAGE_BYTES);
			end
			SEQ_READ: begin
				spi.cmd_valid = !r_issued;
				spi.cmd_len   = 16'(`FLASH_PAGE_BYTES);
			end
			default: spi.cmd_valid = 1'b0;
		endcase
	end
	assign spi.cmd_addr = r_flash_addr;

	//--------------------------------------------------
	// read bytes into ddr words, first byte highest
	//--------------------------------------------------
	// stall the 8th byte while the previous word waits
	assign spi.rd_ready = (r_state == SEQ_READ) && !(r_ddr_valid && r_pack_cnt == 3'd7);

	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_pack_cnt  <= 3'd0;
			r_ddr_valid <= 1'b0;
			r_ddr_addr  <= '0;
			r_word_cnt  <= 16'd0;
			r_load_done <= 1'b0;
		end else begin
			r_load_done <= w_ddr_fire &&
				(r_word_cnt == 16'(r_pages * (`FLASH_PAGE_BYTES / 8)) - 16'd1);
			if (w_load_start) begin
				r_pack_cnt <= 3'd0;
				r_ddr_addr <= '0;
				r_word_cnt <= 16'd0;
			end else begin
				if (w_rd_fire) begin
					r_pack_cnt <= r_pack_cnt + 3'd1;
					if (r_pack_cnt == 3'd7) begin
						r_ddr_valid <= 1'b1;
					end
				end
				if (w_ddr_fire) begin
					r_ddr_valid <= 1'b0;
					r_ddr_addr  <= r_ddr_addr + `DDR_ADDR_W'(`DDR_ADDR_STEP);
					r_word_cnt  <= r_word_cnt + 16'd1;
				end
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_rd_fire) begin
			r_pack <= {r_pack[`DDR_DATA_W-9:0], spi.rd_data};
			if (r_pack_cnt == 3'd7) begin
				r_ddr_data <= {r_pack[`DDR_DATA_W-9:0], spi.rd_data};
			end
		end
	end

	assign o_ddr_wr_valid = r_ddr_valid;
	assign o_ddr_wr_addr  = r_ddr_addr;
	assign o_ddr_wr_data  = r_ddr_data;
	assign o_load_done    = r_load_done;

	//--------------------------------------------------
	// fifo words into program bytes, high byte first
	//--------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_word_full <= 1'b0;
			r_half      <= 1'b0;
			r_fifo_cnt  <= 8'd0;
		end else begin
			if (w_fifo_fire) begin
				r_word_full <= 1'b1;
				r_fifo_cnt  <= r_fifo_cnt + 8'd1;
			end else if (spi.wr_valid && spi.wr_ready) begin
				r_half <= !r_half;
				if (r_half) begin
					r_word_full <= 1'b0;
				end
			end
			if (r_state == SEQ_PROGRAM && spi.cmd_done) begin
				r_fifo_cnt <= 8'd0;
			end
		end
	end

	always_ff @(posedge i_clk) begin
		if (w_fifo_fire) begin
			r_fifo_word <= i_fifo_data;
		end
	end

	// fetch no further than the current page
	assign o_fifo_ready = (r_state == SEQ_PROGRAM) && !r_word_full && (r_fifo_cnt != PAGE_WORDS);
	assign spi.wr_valid = (r_state == SEQ_PROGRAM) && r_word_full;
	assign spi.wr_data  = r_half ? r_fifo_word[7:0] : r_fifo_word[15:8];

endmodule

// File: hw/region_cfg.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module region_cfg (
	input  logic                      i_clk,
	input  logic                      i_rst_n,
	input  logic                      i_req_valid,
	input  flash_ctrl_pkg::req_kind_e i_req_kind,
	input  logic [2:0]                i_code_packet,
	output logic                      o_req_ready,
	input  logic                      i_op_start,
	input  logic                      i_op_done,
	output logic                      o_op_pending,
	output logic                      o_op_save,
	output logic                      o_op_reload,
	output logic [`FLASH_ADDR_W-1:0]  o_op_base,
	output logic [15:0]               o_op_pages
);
	import flash_ctrl_pkg::*;

	req_kind_e  r_kind;
	logic [2:0] r_packet;
	logic       r_pending;
	logic       r_busy;

	// comes out of reset holding the boot load
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_pending <= 1'b1;
			r_busy    <= 1'b0;
			r_kind    <= REQ_LOAD_PARAM;
			r_packet  <= 3'd0;
		end else begin
			if (i_req_valid && o_req_ready) begin
				r_pending <= 1'b1;
				r_kind    <= i_req_kind;
				r_packet  <= i_code_packet;
			end else if (i_op_start) begin
				r_pending <= 1'b0;
			end
			if (i_op_start) begin
				r_busy <= 1'b1;
			end else if (i_op_done) begin
				r_busy <= 1'b0;
			end
		end
	end

	assign o_req_ready  = !r_pending && !r_busy;
	assign o_op_pending = r_pending;

	// region table
	always_comb begin
		o_op_save   = 1'b1;
		o_op_reload = 1'b1;
		o_op_base   = `PARAM_BASE;
		o_op_pages  = 16'(`PARAM_PAGES);
		case (r_kind)
			REQ_SAVE_FACTORY: o_op_base = `FACTORY_BASE;
			REQ_SAVE_COE: begin
				o_op_base  = `COE_BASE;
				o_op_pages = 16'(`COE_PAGES);
			end
			REQ_SAVE_CODE: begin
				o_op_reload = 1'b0;
				o_op_base   = `FLASH_ADDR_W'(r_packet) * `CODE_PACKET_SPAN;
				o_op_pages  = 16'(`CODE_PAGES);
			end
			REQ_LOAD_PARAM: begin
				o_op_save   = 1'b0;
				o_op_reload = 1'b0;
			end
			default: o_op_base = `PARAM_BASE;
		endcase
	end

endmodule

// File: hw/spi_flash_engine.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

module spi_flash_engine (
	input  logic     i_clk,
	input  logic     i_rst_n,
	spi_cmd_if.slave spi,
	output logic     o_cs_n,
	output logic     o_sck,
	output logic     o_mosi,
	input  logic     i_miso
);
	import flash_ctrl_pkg::*;

	eng_state_e               r_state;
	flash_op_e                r_op;
	logic [`FLASH_ADDR_W-1:0] r_addr;
	logic [15:0]              r_len;
	logic [16:0]              r_byte_idx;
	logic [2:0]               r_bit_cnt;
	logic [7:0]               r_div_cnt;
	logic [7:0]               r_tx_sr;
	logic [7:0]               r_rx_sr;
	logic                     r_cs_n;
	logic                     r_sck;

	logic                     w_div_tick;
	logic [16:0]              w_hdr_bytes;
	logic [16:0]              w_total;
	logic                     w_rd_byte;

	assign w_div_tick  = (r_div_cnt == 8'(`SCK_HALF_DIV - 1));
	// write enable has no address bytes
	assign w_hdr_bytes = (r_op == OP_WREN) ? 17'd1 : 17'd4;
	assign w_total     = {1'b0, r_len} + w_hdr_bytes;
	assign w_rd_byte   = (r_op == OP_READ) && (r_byte_idx >= 17'd4);

	//--------------------------------------------------
	// byte and bit sequencing
	//--------------------------------------------------
	always_ff @(posedge i_clk or negedge i_rst_n) begin
		if (!i_rst_n) begin
			r_state    <= ENG_IDLE;
			r_cs_n     <= 1'b1;
			r_sck      <= 1'b0;
			r_tx_sr    <= 8'h00;
			r_div_cnt  <= 8'd0;
			r_bit_cnt  <= 3'd0;
			r_byte_idx <= 17'd0;
		end else begin
			case (r_state)
				ENG_IDLE: begin
					if (spi.cmd_valid) begin
						r_cs_n     <= 1'b0;
						r_tx_sr    <= spi.cmd_op;
						r_byte_idx <= 17'd0;
						r_state    <= ENG_SHIFT;
					end
				end
				ENG_SHIFT: begin
					if (w_div_tick) begin
						r_div_cnt <= 8'd0;
						if (!r_sck) begin
							r_sck <= 1'b1;
						end else begin
							r_sck <= 1'b0;
							if (r_bit_cnt == 3'd7) begin
								r_bit_cnt  <= 3'd0;
								r_byte_idx <= r_byte_idx + 17'd1;
								r_state    <= w_rd_byte ? ENG_RD : ENG_LOAD;
							end else begin
								r_bit_cnt <= r_bit_cnt + 3'd1;
								r_tx_sr   <= {r_tx_sr[6:0], 1'b0};
							end
						end
					end else begin
						r_div_cnt <= r_div_cnt + 8'd1;
					end
				end
				// pick the next byte, sck stays low here
				ENG_LOAD: begin
					if (r_byte_idx == w_total) begin
						r_state <= ENG_END;
					end else if (r_byte_idx < w_hdr_bytes) begin
						case (r_byte_idx[1:0])
							2'd1:    r_tx_sr <= r_addr[23:16];
							2'd2:    r_tx_sr <= r_addr[15:8];
							default: r_tx_sr <= r_addr[7:0];
						endcase
						r_state <= ENG_SHIFT;
					end else if (r_op == OP_PROGRAM) begin
						r_state <= ENG_WR;
					end else begin
						r_tx_sr <= 8'h00;
						r_state <= ENG_SHIFT;
					end
				end
				ENG_WR: begin
					if (spi.wr_valid) begin
						r_tx_sr <= spi.wr_data;
						r_state <= ENG_SHIFT;
					end
				end
				ENG_RD: begin
					if (spi.rd_ready) begin
						r_state <= ENG_LOAD;
					end
				end
				// hold cs low for half a period after the last edge
				ENG_END: begin
					if (w_div_tick) begin
						r_div_cnt <= 8'd0;
						r_cs_n    <= 1'b1;
						r_tx_sr   <= 8'h00;
						r_state   <= ENG_DONE;
					end else begin
						r_div_cnt <= r_div_cnt + 8'd1;
					end
				end
				default: begin
					r_state <= ENG_IDLE;
				end
			endcase
		end
	end

	// command fields and miso capture
	always_ff @(posedge i_clk) begin
		if (r_state == ENG_IDLE && spi.cmd_valid) begin
			r_op   <= spi.cmd_op;
			r_addr <= spi.cmd_addr;
			r_len  <= spi.cmd_len;
		end
		// sample on the rising edge
		if (r_state == ENG_SHIFT && w_div_tick && !r_sck) begin
			r_rx_sr <= {r_rx_sr[6:0], i_miso};
		end
	end

	assign spi.cmd_ready = (r_state == ENG_IDLE);
	assign spi.cmd_done  = (r_state == ENG_DONE);
	assign spi.wr_ready  = (r_state == ENG_WR);
	assign spi.rd_valid  = (r_state == ENG_RD);
	assign spi.rd_data   = r_rx_sr;

	assign o_cs_n = r_cs_n;
	assign o_sck  = r_sck;
	assign o_mosi = r_tx_sr[7];

endmodule

// File: hw/spi_cmd_if.sv
`timescale 1ns/1ps
`include "flash_ctrl_config.svh"

interface spi_cmd_if;
	import flash_ctrl_pkg::*;

	// command channel
	logic                     cmd_valid;
	logic                     cmd_ready;
	flash_op_e                cmd_op;
	logic [`FLASH_ADDR_W-1:0] cmd_addr;
	logic [15:0]              cmd_len;
	logic                     cmd_done;

	// program bytes toward the flash
	logic                     wr_valid;
	logic                     wr_ready;
	logic [7:0]               wr_data;

	// read bytes from the flash
	logic                     rd_valid;
	logic                     rd_ready;
	logic [7:0]               rd_data;

	modport master (
		output cmd_valid, cmd_op, cmd_addr, cmd_len, wr_valid, wr_data, rd_ready,
		input  cmd_ready, cmd_done, wr_ready, rd_valid, rd_data
	);

	modport slave (
		input  cmd_valid, cmd_op, cmd_addr, cmd_len, wr_valid, wr_data, rd_ready,
		output cmd_ready, cmd_done, wr_ready, rd_valid, rd_data
	);

endinterface

// File: hw/flash_ctrl_pkg.sv
package flash_ctrl_pkg;

	// serial nor opcodes
	typedef enum logic [7:0] {
		OP_PROGRAM = 8'h02,
		OP_READ    = 8'h03,
		OP_WREN    = 8'h06,
		OP_ERASE   = 8'hD8
	} flash_op_e;

	typedef enum logic [2:0] {
		REQ_SAVE_PARAM,
		REQ_SAVE_FACTORY,
		REQ_SAVE_COE,
		REQ_SAVE_CODE,
		REQ_LOAD_PARAM
	} req_kind_e;

	typedef enum logic [3:0] {
		SEQ_IDLE,
		SEQ_ERASE_WREN,
		SEQ_ERASE,
		SEQ_ERASE_WAIT,
		SEQ_PROG_WREN,
		SEQ_PROGRAM,
		SEQ_PROG_WAIT,
		SEQ_READ,
		SEQ_LOAD_WAIT,
		SEQ_DONE
	} seq_state_e;

	typedef enum logic [2:0] {
		ENG_IDLE,
		ENG_SHIFT,
		ENG_LOAD,
		ENG_WR,
		ENG_RD,
		ENG_END,
		ENG_DONE
	} eng_state_e;

endpackage

// File: include/flash_ctrl_config.svh
`ifndef FLASH_CTRL_CONFIG_SVH
`define FLASH_CTRL_CONFIG_SVH

// flash geometry
`define FLASH_ADDR_W        24
`define FLASH_PAGE_BYTES    32
`define FLASH_BLOCK_BYTES   65536

// ddr write port
`define DDR_DATA_W          64
`define DDR_ADDR_W          27
`define DDR_ADDR_STEP       4

// word fifo source
`define FIFO_DATA_W         16

// system clocks per sck half period
`define SCK_HALF_DIV        2

// region table
`define PARAM_BASE          24'h200000
`define FACTORY_BASE        24'h0B0000
`define COE_BASE            24'h0C0000
`define CODE_PACKET_SPAN    24'h020000
`define PARAM_PAGES         3
`define COE_PAGES           4
`define CODE_PAGES          2

// fixed waits in place of busy polling
`define ERASE_WAIT_CYCLES   64
`define PROGRAM_WAIT_CYCLES 32

`endif
